// File: Bender.yml
package:
  name: uart_controller

sources:
  - design/uart_pkg.sv
  - design/uart_fifo.sv
  - design/uart_baud_gen.sv
  - design/uart_tx.sv
  - design/uart_rx.sv
  - design/uart_regs.sv
  - design/uart_controller.sv
  - target: test
    files:
      - verification/tb_uart_controller.sv

// File: design/uart_baud_gen.sv
`timescale 1ns/10ps

module uart_baud_gen (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        enable_i,
    input  logic [15:0] divisor_i,
    output logic        tick_o
);

    logic [15:0] count_q;

    // one tick every divisor+1 cycles
    assign tick_o = enable_i && (count_q == 16'd0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (!enable_i) begin
            // restart from zero so the first tick comes right after enable
            count_q <= '0;
        end else if (count_q == 16'd0) begin
            count_q <= divisor_i;
        end else begin
            count_q <= count_q - 16'd1;
        end
    end

endmodule

// File: design/uart_controller.sv
`timescale 1ns/10ps

module uart_controller #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk_i,
    input  logic               reset_i,
    input  uart_pkg::bus_req_t req_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    output logic [31:0]        resp_data_o,
    output logic               resp_valid_o,
    input  logic               resp_ready_i,
    input  logic               rx_i,
    output logic               tx_o
);

    import uart_pkg::*;

    ctrl_t      ctrl;
    logic       baud_tick;
    logic       tx_push;
    logic       tx_pop;
    logic       tx_full;
    logic       tx_empty;
    logic [7:0] tx_wdata;
    logic [7:0] tx_rdata;
    logic       rx_push;
    logic       rx_pop;
    logic       rx_full;
    logic       rx_empty;
    logic [7:0] rx_wdata;
    logic [7:0] rx_rdata;
    logic       frame_err;

    uart_regs #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_regs (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .resp_data_o (resp_data_o),
        .resp_valid_o(resp_valid_o),
        .resp_ready_i(resp_ready_i),
        .ctrl_o      (ctrl),
        .tx_push_o   (tx_push),
        .tx_data_o   (tx_wdata),
        .tx_full_i   (tx_full),
        .tx_empty_i  (tx_empty),
        .rx_pop_o    (rx_pop),
        .rx_data_i   (rx_rdata),
        .rx_full_i   (rx_full),
        .rx_empty_i  (rx_empty),
        .frame_err_i (frame_err)
    );

    // oversample tick runs while either direction is on
    uart_baud_gen u_baud_gen (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .enable_i (ctrl.rx_en | ctrl.tx_en),
        .divisor_i(ctrl.divisor),
        .tick_o   (baud_tick)
    );

    uart_fifo #(
        .DEPTH(FIFO_DEPTH),
        .WIDTH(8)
    ) u_tx_fifo (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .push_i (tx_push),
        .data_i (tx_wdata),
        .pop_i  (tx_pop),
        .data_o (tx_rdata),
        .full_o (tx_full),
        .empty_o(tx_empty)
    );

    uart_fifo #(
        .DEPTH(FIFO_DEPTH),
        .WIDTH(8)
    ) u_rx_fifo (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .push_i (rx_push),
        .data_i (rx_wdata),
        .pop_i  (rx_pop),
        .data_o (rx_rdata),
        .full_o (rx_full),
        .empty_o(rx_empty)
    );

    uart_tx u_tx (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .enable_i    (ctrl.tx_en),
        .tick_i      (baud_tick),
        .fifo_empty_i(tx_empty),
        .fifo_data_i (tx_rdata),
        .fifo_pop_o  (tx_pop),
        .tx_o        (tx_o)
    );

    uart_rx u_rx (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .enable_i   (ctrl.rx_en),
        .tick_i     (baud_tick),
        .rx_i       (rx_i),
        .fifo_full_i(rx_full),
        .push_o     (rx_push),
        .data_o     (rx_wdata),
        .frame_err_o(frame_err)
    );

endmodule

// File: design/uart_fifo.sv
`timescale 1ns/10ps

module uart_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 8
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             push_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] data_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    assign data_o  = mem_q[rd_ptr_q];
    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // wrap by compare, depth need not be a power of two
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i) push_i |-> !full_o)
        else $error("uart_fifo: push while full");
    a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i) pop_i |-> !empty_o)
        else $error("uart_fifo: pop while empty");

endmodule

// File: design/uart_pkg.sv
package uart_pkg;

    // peripheral base, four word registers above it
    localparam logic [31:0] UART_BASE_ADDR = 32'h2000_0000;

    // word index of each register, byte offsets 0x0, 0x4, 0x8 and 0xc
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_STATUS = 2'd1,
        REG_RXDATA = 2'd2,
        REG_TXDATA = 2'd3
    } reg_e;

    // control register bit positions
    localparam int CTRL_RX_EN_BIT = 0;
    localparam int CTRL_TX_EN_BIT = 1;
    localparam int CTRL_DIV_LSB   = 16;

    // 16x oversampling, last tick of a bit and mid-bit tick
    localparam logic [3:0] OVS_LAST = 4'd15;
    localparam logic [3:0] OVS_MID  = 4'd7;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        write;
    } bus_req_t;

    typedef struct packed {
        logic        rx_en;
        logic        tx_en;
        logic [15:0] divisor;
    } ctrl_t;

    // declared msb first so the struct lines up with register bits 4:0
    typedef struct packed {
        logic frame_err;
        logic rx_empty;
        logic rx_full;
        logic tx_empty;
        logic tx_full;
    } status_t;

    typedef enum logic [1:0] {
        TX_IDLE, TX_START, TX_DATA, TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE, RX_START, RX_DATA, RX_STOP
    } rx_state_e;

endpackage

// File: design/uart_regs.sv
`timescale 1ns/10ps

module uart_regs #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk_i,
    input  logic               reset_i,
    input  uart_pkg::bus_req_t req_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    output logic [31:0]        resp_data_o,
    output logic               resp_valid_o,
    input  logic               resp_ready_i,
    output uart_pkg::ctrl_t    ctrl_o,
    output logic               tx_push_o,
    output logic [7:0]         tx_data_o,
    input  logic               tx_full_i,
    input  logic               tx_empty_i,
    output logic               rx_pop_o,
    input  logic [7:0]         rx_data_i,
    input  logic               rx_full_i,
    input  logic               rx_empty_i,
    input  logic               frame_err_i
);

    import uart_pkg::*;

    // fifo pointers need at least two entries
    if (FIFO_DEPTH < 2) begin : g_depth_check
        $error("uart_regs: FIFO_DEPTH must be at least 2");
    end

    ctrl_t       ctrl_q;
    logic        frame_err_q;
    logic        active_q;
    logic        resp_valid_q;
    logic [31:0] resp_data_q;
    logic        addr_hit;
    reg_e        reg_sel;
    logic        txdata_wr;
    logic        req_fire;
    logic        wr_fire;
    logic        rd_fire;
    status_t     status;
    logic [31:0] rd_data;

    // base match and word alignment
    assign addr_hit  = (req_i.addr[31:4] == UART_BASE_ADDR[31:4]) && (req_i.addr[1:0] == 2'b00);
    assign reg_sel   = reg_e'(req_i.addr[3:2]);
    assign txdata_wr = req_i.write && addr_hit && (reg_sel == REG_TXDATA);

    // stall while a response waits or the tx fifo cannot take the byte
    assign req_ready_o = active_q && !resp_valid_q && !(txdata_wr && tx_full_i);
    assign req_fire    = req_valid_i && req_ready_o;
    assign wr_fire     = req_fire && req_i.write;
    assign rd_fire     = req_fire && !req_i.write;

    assign tx_push_o = req_fire && txdata_wr;
    assign tx_data_o = req_i.wdata[7:0];
    assign rx_pop_o  = rd_fire && addr_hit && (reg_sel == REG_RXDATA) && !rx_empty_i;

    assign status = '{
        frame_err: frame_err_q,
        rx_empty:  rx_empty_i,
        rx_full:   rx_full_i,
        tx_empty:  tx_empty_i,
        tx_full:   tx_full_i
    };

    always_comb begin
        rd_data = '0;
        if (addr_hit) begin
            case (reg_sel)
                REG_CTRL: begin
                    rd_data[CTRL_RX_EN_BIT]  = ctrl_q.rx_en;
                    rd_data[CTRL_TX_EN_BIT]  = ctrl_q.tx_en;
                    rd_data[31:CTRL_DIV_LSB] = ctrl_q.divisor;
                end
                REG_STATUS: rd_data[$bits(status_t)-1:0] = status;
                REG_RXDATA: begin
                    if (!rx_empty_i) begin
                        rd_data[7:0] = rx_data_i;
                    end
                end
                // txdata is write-only
                default: rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ctrl_q       <= '0;
            frame_err_q  <= 1'b0;
            active_q     <= 1'b0;
            resp_valid_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
            if (wr_fire && addr_hit && (reg_sel == REG_CTRL)) begin
                ctrl_q.rx_en   <= req_i.wdata[CTRL_RX_EN_BIT];
                ctrl_q.tx_en   <= req_i.wdata[CTRL_TX_EN_BIT];
                ctrl_q.divisor <= req_i.wdata[31:CTRL_DIV_LSB];
            end
            // a new error wins over the clear from a status read
            if (frame_err_i) begin
                frame_err_q <= 1'b1;
            end else if (rd_fire && addr_hit && (reg_sel == REG_STATUS)) begin
                frame_err_q <= 1'b0;
            end
            if (rd_fire) begin
                resp_valid_q <= 1'b1;
            end else if (resp_ready_i) begin
                resp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_fire) begin
            resp_data_q <= rd_data;
        end
    end

    assign resp_valid_o = resp_valid_q;
    assign resp_data_o  = resp_data_q;
    assign ctrl_o       = ctrl_q;

    // response held under back-pressure
    property p_resp_hold;
        @(posedge clk_i) disable iff (reset_i)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o);
    endproperty
    a_resp_hold: assert property (p_resp_hold)
        else $error("uart_regs: response changed while stalled");

endmodule

// File: design/uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       enable_i,
    input  logic       tick_i,
    input  logic       rx_i,
    input  logic       fifo_full_i,
    output logic       push_o,
    output logic [7:0] data_o,
    output logic       frame_err_o
);

    import uart_pkg::*;

    rx_state_e  state_q;
    logic [1:0] sync_q;
    logic       rx_prev_q;
    logic       rx_s;
    logic [3:0] tick_cnt_q;
    logic [2:0] bit_cnt_q;
    logic [7:0] shift_q;
    logic       push_q;
    logic       frame_err_q;
    logic       start_edge;
    logic       sample;

    assign rx_s       = sync_q[1];
    assign start_edge = enable_i && rx_prev_q && !rx_s;

    // start bit is checked at mid-bit, later bits one full bit apart
    assign sample = tick_i && (tick_cnt_q == ((state_q == RX_START) ? OVS_MID : OVS_LAST));

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sync_q    <= 2'b11;
            rx_prev_q <= 1'b1;
        end else begin
            sync_q    <= {sync_q[0], rx_i};
            rx_prev_q <= rx_s;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= RX_IDLE;
            tick_cnt_q  <= '0;
            bit_cnt_q   <= '0;
            push_q      <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            push_q      <= 1'b0;
            frame_err_q <= 1'b0;
            if ((state_q != RX_IDLE) && tick_i) begin
                tick_cnt_q <= tick_cnt_q + 4'd1;
            end
            case (state_q)
                RX_IDLE: begin
                    if (start_edge) begin
                        state_q    <= RX_START;
                        tick_cnt_q <= '0;
                    end
                end
                RX_START: begin
                    if (sample) begin
                        tick_cnt_q <= '0;
                        bit_cnt_q  <= '0;
                        // line back high, just a glitch
                        state_q    <= rx_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (sample) begin
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 3'd1;
                        end
                    end
                end
                RX_STOP: begin
                    if (sample) begin
                        state_q <= RX_IDLE;
                        // byte dropped when the fifo is full
                        if (rx_s) begin
                            push_q <= !fifo_full_i;
                        end else begin
                            frame_err_q <= 1'b1;
                        end
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == RX_DATA) && sample) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
    end

    assign push_o      = push_q;
    assign data_o      = shift_q;
    assign frame_err_o = frame_err_q;

endmodule

// File: design/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       enable_i,
    input  logic       tick_i,
    input  logic       fifo_empty_i,
    input  logic [7:0] fifo_data_i,
    output logic       fifo_pop_o,
    output logic       tx_o
);

    import uart_pkg::*;

    tx_state_e  state_q;
    logic [3:0] tick_cnt_q;
    logic [2:0] bit_cnt_q;
    logic [7:0] shift_q;
    logic       tx_q;
    logic       bit_done;

    // sixteenth tick of the current bit
    assign bit_done = tick_i && (tick_cnt_q == OVS_LAST);

    // enable only gates the start, a running frame always completes
    assign fifo_pop_o = (state_q == TX_IDLE) && tick_i && enable_i && !fifo_empty_i;
    assign tx_o       = tx_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q    <= TX_IDLE;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            tx_q       <= 1'b1;
        end else begin
            // free-running within a bit, wraps at 16
            if ((state_q != TX_IDLE) && tick_i) begin
                tick_cnt_q <= tick_cnt_q + 4'd1;
            end
            case (state_q)
                TX_IDLE: begin
                    if (fifo_pop_o) begin
                        state_q    <= TX_START;
                        tick_cnt_q <= '0;
                        tx_q       <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state_q   <= TX_DATA;
                        bit_cnt_q <= '0;
                        tx_q      <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= TX_STOP;
                            tx_q    <= 1'b1;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 3'd1;
                            tx_q      <= shift_q[1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        state_q <= TX_IDLE;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk_i) begin
        if (fifo_pop_o) begin
            shift_q <= fifo_data_i;
        end else if ((state_q == TX_DATA) && bit_done) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// File: sources.f
design/uart_pkg.sv
design/uart_fifo.sv
design/uart_baud_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/uart_controller.sv
verification/tb_uart_controller.sv

// File: verification/tb_uart_controller.sv
`timescale 1ns/10ps

module tb_uart_controller;

    import uart_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DIVISOR    = 1;
    localparam int BIT_CYCLES = 16 * (DIVISOR + 1);
    // 25 frames of 320 cycles plus bus traffic and margin
    localparam int TIMEOUT_CYCLES = 12000;

    localparam logic [31:0] ADDR_CTRL     = UART_BASE_ADDR + 32'h0;
    localparam logic [31:0] ADDR_STATUS   = UART_BASE_ADDR + 32'h4;
    localparam logic [31:0] ADDR_RXDATA   = UART_BASE_ADDR + 32'h8;
    localparam logic [31:0] ADDR_TXDATA   = UART_BASE_ADDR + 32'hc;
    localparam logic [31:0] ADDR_UNMAPPED = UART_BASE_ADDR + 32'h10;

    // divisor in bits 31:16 with rx_en at bit 0 and tx_en at bit 1
    localparam logic [31:0] CTRL_IDLE = 32'(DIVISOR) << 16;
    localparam logic [31:0] CTRL_RX   = CTRL_IDLE | 32'h1;
    localparam logic [31:0] CTRL_TX   = CTRL_IDLE | 32'h2;

    logic        clk;
    logic        reset;
    bus_req_t    req;
    logic        req_valid;
    logic        req_ready;
    logic [31:0] resp_data;
    logic        resp_valid;
    logic        resp_ready;
    logic        rx;
    logic        tx;
    integer      seed;
    int          cycle_count = 0;

    uart_controller #(
        .FIFO_DEPTH(4)
    ) UUT (
        .clk_i       (clk),
        .reset_i     (reset),
        .req_i       (req),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .resp_data_o (resp_data),
        .resp_valid_o(resp_valid),
        .resp_ready_i(resp_ready),
        .rx_i        (rx),
        .tx_o        (tx)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // status register layout from bit 0 upward
    function automatic logic [31:0] status_word(input logic tx_full, input logic tx_empty,
                                                input logic rx_full, input logic rx_empty,
                                                input logic frame_err);
        status_word = {27'd0, frame_err, rx_empty, rx_full, tx_empty, tx_full};
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        req       = '{addr: addr, wdata: data, write: 1'b1};
        req_valid = 1'b1;
        #1;
        while (!req_ready) begin
            @(negedge clk);
            #1;
        end
        // accepted on the rising edge in between
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                            input int hold_cycles);
        @(negedge clk);
        req        = '{addr: addr, wdata: 32'd0, write: 1'b0};
        req_valid  = 1'b1;
        resp_ready = (hold_cycles == 0);
        #1;
        while (!req_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        req_valid = 1'b0;
        // request bus goes idle while the response waits
        req       = '0;
        while (!resp_valid) begin
            @(negedge clk);
        end
        data = resp_data;
        // host stalls the response
        for (int i = 0; i < hold_cycles; i++) begin
            @(negedge clk);
            check(resp_valid, 1'b1, "resp_valid under back-pressure");
            check(resp_data, data, "resp_data under back-pressure");
            check(req_ready, 1'b0, "req_ready while response waits");
        end
        if (hold_cycles > 0) begin
            resp_ready = 1'b1;
            @(negedge clk);
            check(resp_valid, 1'b0, "resp_valid after release");
        end
    endtask

    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        @(negedge clk);
        rx = 1'b0;
        wait_cycles(BIT_CYCLES);
        for (int i = 0; i < 8; i++) begin
            rx = data[i];
            wait_cycles(BIT_CYCLES);
        end
        rx = stop_bit;
        wait_cycles(BIT_CYCLES);
        rx = 1'b1;
    endtask

    // returns at the centre of the stop bit
    task automatic expect_frame(input logic [7:0] data);
        @(negedge clk);
        while (tx !== 1'b0) begin
            @(negedge clk);
        end
        wait_cycles(BIT_CYCLES / 2);
        check(tx, 1'b0, "tx start bit");
        for (int i = 0; i < 8; i++) begin
            wait_cycles(BIT_CYCLES);
            check(tx, data[i], "tx data bit");
        end
        wait_cycles(BIT_CYCLES);
        check(tx, 1'b1, "tx stop bit");
    endtask

    task automatic check_reset_values;
        logic [31:0] rdata;
        bus_read(ADDR_CTRL, rdata, 0);
        check(rdata, 32'd0, "ctrl after reset");
        bus_read(ADDR_STATUS, rdata, 0);
        check(rdata, status_word(0, 1, 0, 1, 0), "status after reset");
        check(tx, 1'b1, "tx idle after reset");
    endtask

    task automatic ctrl_readback;
        logic [31:0] wdata;
        logic [31:0] rdata;
        wdata = 32'ha5c3_7ffe;
        bus_write(ADDR_CTRL, wdata);
        bus_read(ADDR_CTRL, rdata, 0);
        check(rdata, {wdata[31:16], 14'd0, wdata[1:0]}, "ctrl readback");
        bus_write(ADDR_UNMAPPED, 32'hffff_ffff);
        bus_read(ADDR_UNMAPPED, rdata, 0);
        check(rdata, 32'd0, "unmapped read");
        bus_read(ADDR_CTRL, rdata, 0);
        check(rdata, {wdata[31:16], 14'd0, wdata[1:0]}, "ctrl after unmapped write");
        bus_write(ADDR_CTRL, 32'd0);
    endtask

    task automatic transmit_bytes;
        logic [7:0]  sent [4];
        logic [31:0] rand_word;
        logic [31:0] rdata;
        for (int batch = 0; batch < 2; batch++) begin
            bus_write(ADDR_CTRL, CTRL_IDLE);
            for (int i = 0; i < 4; i++) begin
                rand_word = $random(seed);
                sent[i]   = rand_word[7:0];
                bus_write(ADDR_TXDATA, {24'd0, sent[i]});
            end
            // first frame starts on the first tick after enable
            bus_write(ADDR_CTRL, CTRL_TX);
            for (int i = 0; i < 4; i++) begin
                expect_frame(sent[i]);
            end
            wait_cycles(BIT_CYCLES);
        end
        bus_read(ADDR_STATUS, rdata, 0);
        check(rdata, status_word(0, 1, 0, 1, 0), "status after transmit");
        bus_write(ADDR_CTRL, CTRL_IDLE);
    endtask

    task automatic receive_bytes;
        logic [7:0]  sent [4];
        logic [31:0] rand_word;
        logic [31:0] rdata;
        bus_write(ADDR_CTRL, CTRL_RX);
        for (int batch = 0; batch < 2; batch++) begin
            for (int i = 0; i < 4; i++) begin
                rand_word = $random(seed);
                sent[i]   = rand_word[7:0];
                send_frame(sent[i], 1'b1);
            end
            if (batch == 0) begin
                bus_read(ADDR_STATUS, rdata, 0);
                check(rdata, status_word(0, 1, 1, 0, 0), "status with rx fifo full");
                // byte dropped while the rx fifo is full
                rand_word = $random(seed);
                send_frame(rand_word[7:0], 1'b1);
            end
            for (int i = 0; i < 4; i++) begin
                bus_read(ADDR_RXDATA, rdata, 0);
                check(rdata, {24'd0, sent[i]}, "rx data");
            end
        end
        bus_read(ADDR_RXDATA, rdata, 0);
        check(rdata, 32'd0, "read of empty rx fifo");
        // receiver off so the frame is ignored
        bus_write(ADDR_CTRL, CTRL_IDLE);
        rand_word = $random(seed);
        send_frame(rand_word[7:0], 1'b1);
        bus_read(ADDR_STATUS, rdata, 0);
        check(rdata, status_word(0, 1, 0, 1, 0), "status with rx disabled");
    endtask

    task automatic stall_on_full_fifo;
        logic [7:0]  sent [5];
        logic [31:0] rand_word;
        logic [31:0] rdata;
        bus_write(ADDR_CTRL, CTRL_IDLE);
        for (int i = 0; i < 5; i++) begin
            rand_word = $random(seed);
            sent[i]   = rand_word[7:0];
        end
        for (int i = 0; i < 4; i++) begin
            bus_write(ADDR_TXDATA, {24'd0, sent[i]});
        end
        bus_read(ADDR_STATUS, rdata, 0);
        check(rdata, status_word(1, 0, 0, 1, 0), "status with tx fifo full");
        bus_read(ADDR_CTRL, rdata, 4);
        check(rdata, CTRL_IDLE, "ctrl read under back-pressure");
        // fifth byte must not be accepted
        @(negedge clk);
        req       = '{addr: ADDR_TXDATA, wdata: {24'd0, sent[4]}, write: 1'b1};
        req_valid = 1'b1;
        repeat (6) begin
            #1;
            check(req_ready, 1'b0, "req_ready with tx fifo full");
            @(negedge clk);
        end
        req_valid = 1'b0;
        bus_write(ADDR_CTRL, CTRL_TX);
        // accepted once the first pop frees a slot
        bus_write(ADDR_TXDATA, {24'd0, sent[4]});
        for (int i = 0; i < 5; i++) begin
            expect_frame(sent[i]);
        end
        wait_cycles(BIT_CYCLES);
        bus_write(ADDR_CTRL, CTRL_IDLE);
    endtask

    task automatic detect_frame_error;
        logic [31:0] rand_word;
        logic [31:0] rdata;
        bus_write(ADDR_CTRL, CTRL_RX);
        rand_word = $random(seed);
        send_frame(rand_word[7:0], 1'b0);
        wait_cycles(4);
        bus_read(ADDR_STATUS, rdata, 0);
        check(rdata, status_word(0, 1, 0, 1, 1), "status after bad stop bit");
        bus_read(ADDR_STATUS, rdata, 0);
        check(rdata, status_word(0, 1, 0, 1, 0), "frame_err cleared by read");
        bus_read(ADDR_RXDATA, rdata, 0);
        check(rdata, 32'd0, "no byte from bad frame");
        // receiver recovers on the next good frame
        rand_word = $random(seed);
        send_frame(rand_word[7:0], 1'b1);
        bus_read(ADDR_RXDATA, rdata, 0);
        check(rdata, {24'd0, rand_word[7:0]}, "rx data after frame error");
        bus_write(ADDR_CTRL, CTRL_IDLE);
    endtask

    initial begin
        seed       = 32'h6637_3e0c;
        clk        = 1'b0;
        reset      = 1'b1;
        req        = '0;
        req_valid  = 1'b0;
        resp_ready = 1'b1;
        rx         = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check(req_ready, 1'b0, "req_ready during reset");
            check(resp_valid, 1'b0, "resp_valid during reset");
        end
        reset = 1'b0;
        check_reset_values();
        ctrl_readback();
        transmit_bytes();
        receive_bytes();
        stall_on_full_fifo();
        detect_frame_error();
        $display("all tests passed");
        $finish;
    end

endmodule
